/* conv_consts.svh */
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Ifmap and filter sample width
`define CONV_DATA_W 16

// Product and partial sum width, sums wrap here
`define CONV_ACC_W 32

////////////////////////////////////////
// Column geometry
////////////////////////////////////////

// Processing elements per column, one kernel row each
`define CONV_ROWS 3

// Largest kernel_size and the width that holds it
`define CONV_MAX_K 7
`define CONV_K_W 3

`endif

/* conv_pkg.sv */
`default_nettype none

`include "conv_consts.svh"

package conv_pkg;

    ////////////////////////////////////////
    // Data types
    ////////////////////////////////////////

    // One signed ifmap or filter sample
    typedef logic signed [`CONV_DATA_W-1:0] sample_t;

    // Signed product, row sum or partial sum
    typedef logic signed [`CONV_ACC_W-1:0] psum_t;

    ////////////////////////////////////////
    // Controller state
    ////////////////////////////////////////

    // IDLE waits for the first product of a window
    // ACCUM is inside a window with more products to come
    typedef enum logic {
        IDLE  = 1'b0,
        ACCUM = 1'b1
    } pe_state_e;

endpackage

`default_nettype wire

/* pe_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_mult (
    input  logic              clk,
    input  logic              rstn,
    input  logic              in_valid,
    input  conv_pkg::sample_t a,
    input  conv_pkg::sample_t b,
    output conv_pkg::psum_t   p,
    output logic              p_valid
);
    import conv_pkg::*;

    // Operand stage
    sample_t a_q;
    sample_t b_q;
    logic    v_q;

    // Valid bit follows the data through both stages
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            v_q     <= 1'b0;
            p_valid <= 1'b0;
        end else begin
            v_q     <= in_valid;
            p_valid <= v_q;
        end
    end

    // Stage 1 latches operands, stage 2 the product
    always_ff @(posedge clk) begin
        a_q <= a;
        b_q <= b;
        // Full signed product fits the accumulator width
        p   <= a_q * b_q;
    end

endmodule

`default_nettype wire

/* pe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module pe_ctrl (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 prod_valid,
    input  logic [`CONV_K_W-1:0] kernel_size,
    output logic                 first,
    output logic                 emit
);
    import conv_pkg::*;

    pe_state_e            state;
    // Products taken so far in the current window
    logic [`CONV_K_W-1:0] cnt;
    logic [`CONV_K_W-1:0] cnt_inc;
    // This product completes the window
    logic                 last;

    ////////////////////////////////////////
    // Window decode
    ////////////////////////////////////////

    assign cnt_inc = cnt + 1'b1;
    assign last    = prod_valid && (cnt_inc == kernel_size);

    // Accumulator loads rather than adds
    assign first   = prod_valid && (state == IDLE);

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
            cnt   <= '0;
            emit  <= 1'b0;
        end else begin
            // Row sum sits in the accumulator one cycle after the last product
            emit <= last;
            if (last) begin
                // kernel_size 1 never leaves IDLE
                state <= IDLE;
                cnt   <= '0;
            end else if (prod_valid) begin
                state <= ACCUM;
                cnt   <= cnt_inc;
            end
        end
    end

endmodule

`default_nettype wire

/* pe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module pe (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 in_valid,
    input  conv_pkg::sample_t    ifmap,
    input  conv_pkg::sample_t    fltr,
    input  logic [`CONV_K_W-1:0] kernel_size,
    input  conv_pkg::psum_t      psum_in,
    output conv_pkg::psum_t      psum_out,
    output logic                 psum_valid
);
    import conv_pkg::*;

    // Multiplier outputs
    psum_t mult_p;
    logic  mult_v;

    // Controls from the sequencer
    logic  first;
    logic  emit;

    // Running row dot product
    psum_t acc;

    ////////////////////////////////////////
    // Multiplier and controller
    ////////////////////////////////////////

    pe_mult u_mult (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .a        (ifmap),
        .b        (fltr),
        .p        (mult_p),
        .p_valid  (mult_v)
    );

    pe_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .prod_valid  (mult_v),
        .kernel_size (kernel_size),
        .first       (first),
        .emit        (emit)
    );

    ////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////

    // First product of a window overwrites the previous row sum
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc <= '0;
        end else if (first) begin
            acc <= mult_p;
        end else if (mult_v) begin
            acc <= acc + mult_p;
        end
    end

    ////////////////////////////////////////
    // Partial-sum stage
    ////////////////////////////////////////

    // Predecessor result lands in the same cycle as emit
    always_ff @(posedge clk) begin
        if (emit) begin
            psum_out <= acc + psum_in;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            psum_valid <= 1'b0;
        end else begin
            psum_valid <= emit;
        end
    end

endmodule

`default_nettype wire

/* row_skew.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module row_skew (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic                                   in_valid,
    input  conv_pkg::sample_t [`CONV_ROWS-1:0]     in_ifmap,
    input  conv_pkg::sample_t [`CONV_ROWS-1:0]     in_fltr,
    output logic              [`CONV_ROWS-1:0]     row_valid,
    output conv_pkg::sample_t [`CONV_ROWS-1:0]     row_ifmap,
    output conv_pkg::sample_t [`CONV_ROWS-1:0]     row_fltr
);
    import conv_pkg::*;

    // Row r runs r cycles behind row 0
    for (genvar r = 0; r < `CONV_ROWS; r++) begin : g_row
        if (r == 0) begin : g_pass
            // Top row goes straight through
            assign row_valid[r] = in_valid;
            assign row_ifmap[r] = in_ifmap[r];
            assign row_fltr[r]  = in_fltr[r];
        end else begin : g_dly
            logic [r-1:0] v_sr;
            sample_t      if_sr [r];
            sample_t      fl_sr [r];

            // Strobe shift register
            always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                    v_sr <= '0;
                end else begin
                    v_sr[0] <= in_valid;
                    for (int i = 1; i < r; i++) begin
                        v_sr[i] <= v_sr[i-1];
                    end
                end
            end

            // Sample shift registers, same depth as the strobe
            always_ff @(posedge clk) begin
                if_sr[0] <= in_ifmap[r];
                fl_sr[0] <= in_fltr[r];
                for (int i = 1; i < r; i++) begin
                    if_sr[i] <= if_sr[i-1];
                    fl_sr[i] <= fl_sr[i-1];
                end
            end

            assign row_valid[r] = v_sr[r-1];
            assign row_ifmap[r] = if_sr[r-1];
            assign row_fltr[r]  = fl_sr[r-1];
        end
    end

endmodule

`default_nettype wire

/* conv_column.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module conv_column (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               in_valid,
    input  conv_pkg::sample_t [`CONV_ROWS-1:0] in_ifmap,
    input  conv_pkg::sample_t [`CONV_ROWS-1:0] in_fltr,
    input  logic [`CONV_K_W-1:0]               kernel_size,
    input  conv_pkg::psum_t                    bias,
    output logic                               out_valid,
    output conv_pkg::psum_t                    out_psum
);
    import conv_pkg::*;

    // Staggered per-row inputs
    logic    [`CONV_ROWS-1:0] row_valid;
    sample_t [`CONV_ROWS-1:0] row_ifmap;
    sample_t [`CONV_ROWS-1:0] row_fltr;

    // Partial-sum chain, link 0 carries the bias
    psum_t                    psum_link [`CONV_ROWS+1];
    logic    [`CONV_ROWS-1:0] pe_valid;

    row_skew u_skew (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_ifmap  (in_ifmap),
        .in_fltr   (in_fltr),
        .row_valid (row_valid),
        .row_ifmap (row_ifmap),
        .row_fltr  (row_fltr)
    );

    assign psum_link[0] = bias;

    // Element r adds its row sum to the result of element r-1
    for (genvar r = 0; r < `CONV_ROWS; r++) begin : g_pe
        pe u_pe (
            .clk         (clk),
            .rstn        (rstn),
            .in_valid    (row_valid[r]),
            .ifmap       (row_ifmap[r]),
            .fltr        (row_fltr[r]),
            .kernel_size (kernel_size),
            .psum_in     (psum_link[r]),
            .psum_out    (psum_link[r+1]),
            .psum_valid  (pe_valid[r])
        );
    end

    // Bottom of the chain is the output pixel
    assign out_psum  = psum_link[`CONV_ROWS];
    assign out_valid = pe_valid[`CONV_ROWS-1];

endmodule

`default_nettype wire

/* tb_conv_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module tb_conv_model #(
    parameter int          N_BACK = 16,
    parameter int          N_GAP  = 16,
    parameter int          N_EXT  = 4,
    parameter int          N_K1   = 8,
    parameter int          N_KMAX = 8,
    parameter logic [31:0] SEED   = 32'hce28
) (
    input  logic                               clk,
    output logic                               rstn,
    output logic                               in_valid,
    output conv_pkg::sample_t [`CONV_ROWS-1:0] in_ifmap,
    output conv_pkg::sample_t [`CONV_ROWS-1:0] in_fltr,
    output logic [`CONV_K_W-1:0]               kernel_size,
    output conv_pkg::psum_t                    bias,
    output logic                               due,
    output conv_pkg::psum_t                    exp_val,
    output int                                 n_pushed,
    output logic                               done
);
    import conv_pkg::*;

    // Skew of the last row plus multiplier, accumulator and psum stages
    localparam int LAT = `CONV_ROWS + 3;

    int    cyc = 0;
    int    k_cur;
    // Expected pixels in window order
    int    exp_cyc_q [$];
    psum_t exp_val_q [$];

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    ////////////////////////////////////////
    // Expected-result queue
    ////////////////////////////////////////

    // Runs after the drive step so the head settles before the negedge check
    always @(posedge clk) begin
        #2;
        while (exp_cyc_q.size() > 0 && exp_cyc_q[0] < cyc) begin
            void'(exp_cyc_q.pop_front());
            void'(exp_val_q.pop_front());
        end
        due     = (exp_cyc_q.size() > 0) && (exp_cyc_q[0] == cyc);
        exp_val = due ? exp_val_q[0] : '0;
    end

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    // Reset with a new kernel_size applied while the column is held
    task automatic apply_reset(input int k);
        rstn        = 1'b0;
        kernel_size = 3'(k);
        k_cur       = k;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
    endtask

    // One window of k_cur strobes with optional random gaps between them
    task automatic run_window(input int gap_max, input bit extreme);
        psum_t sum;
        int    gap;
        sum = bias;
        for (int s = 0; s < k_cur; s++) begin
            if (s > 0 && gap_max > 0) begin
                gap = $urandom_range(gap_max, 0);
                idle_cycles(gap);
            end
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            for (int r = 0; r < `CONV_ROWS; r++) begin
                if (extreme) begin
                    in_ifmap[r] = 16'sh8000;
                    in_fltr[r]  = 16'sh8000;
                end else begin
                    in_ifmap[r] = sample_t'($urandom);
                    in_fltr[r]  = sample_t'($urandom);
                end
                // Sign-extended products summed with a 32-bit wrap
                sum = sum + psum_t'(int'(in_ifmap[r]) * int'(in_fltr[r]));
            end
        end
        exp_cyc_q.push_back(cyc + LAT);
        exp_val_q.push_back(sum);
        n_pushed++;
    endtask

    // Quiet inputs until every queued pixel has been checked
    task automatic drain();
        idle_cycles(1);
        while (exp_cyc_q.size() != 0) begin
            idle_cycles(1);
        end
        idle_cycles(4);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        rstn        = 1'b0;
        in_valid    = 1'b0;
        in_ifmap    = '0;
        in_fltr     = '0;
        kernel_size = 3'd3;
        bias        = '0;
        due         = 1'b0;
        exp_val     = '0;
        n_pushed    = 0;
        done        = 1'b0;
        k_cur       = 3;
        void'($urandom(SEED));

        apply_reset(3);
        // Quiet column after reset
        idle_cycles(20);

        // Back-to-back windows with kernel_size 3
        bias = psum_t'($urandom);
        for (int w = 0; w < N_BACK; w++) begin
            run_window(0, 1'b0);
        end
        drain();

        // Random gaps inside windows
        bias = psum_t'($urandom);
        for (int w = 0; w < N_GAP; w++) begin
            run_window(2, 1'b0);
        end
        drain();

        // Most negative operands everywhere plus a large bias
        bias = 32'sh7fff_0000;
        for (int w = 0; w < N_EXT; w++) begin
            run_window(0, 1'b1);
        end
        drain();

        // Second phase with the smallest then the largest kernel
        apply_reset(1);
        idle_cycles(4);
        bias = psum_t'($urandom);
        for (int w = 0; w < N_K1; w++) begin
            run_window(1, 1'b0);
        end
        drain();

        apply_reset(`CONV_MAX_K);
        idle_cycles(4);
        bias = psum_t'($urandom);
        for (int w = 0; w < N_KMAX; w++) begin
            run_window(0, 1'b0);
        end
        drain();

        done = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_conv_column.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module tb_conv_column;
    import conv_pkg::*;

    ////////////////////////////////////////
    // Run length
    ////////////////////////////////////////

    localparam int          N_BACK       = 16;
    localparam int          N_GAP        = 16;
    localparam int          N_EXT        = 4;
    localparam int          N_K1         = 8;
    localparam int          N_KMAX       = 8;
    localparam int          N_WINDOWS    = N_BACK + N_GAP + N_EXT + N_K1 + N_KMAX;
    localparam int          WATCHDOG_CYC = N_WINDOWS * (`CONV_MAX_K + 2) + 200;
    localparam logic [31:0] SEED         = 32'hce28;

    logic                     clk;
    logic                     rstn;
    logic                     in_valid;
    sample_t [`CONV_ROWS-1:0] in_ifmap;
    sample_t [`CONV_ROWS-1:0] in_fltr;
    logic [`CONV_K_W-1:0]     kernel_size;
    psum_t                    bias;
    logic                     out_valid;
    psum_t                    out_psum;

    // From the reference model
    logic                     due;
    psum_t                    exp_val;
    int                       n_pushed;
    logic                     done;

    // Error tallies
    int n_mismatch   = 0;
    int n_unexpected = 0;
    int n_missing    = 0;
    int n_seen       = 0;

    // 20 ns clock
    initial clk = 1'b0;
    always #10 clk = ~clk;

    conv_column uut (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid    (in_valid),
        .in_ifmap    (in_ifmap),
        .in_fltr     (in_fltr),
        .kernel_size (kernel_size),
        .bias        (bias),
        .out_valid   (out_valid),
        .out_psum    (out_psum)
    );

    tb_conv_model #(
        .N_BACK (N_BACK),
        .N_GAP  (N_GAP),
        .N_EXT  (N_EXT),
        .N_K1   (N_K1),
        .N_KMAX (N_KMAX),
        .SEED   (SEED)
    ) model (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid    (in_valid),
        .in_ifmap    (in_ifmap),
        .in_fltr     (in_fltr),
        .kernel_size (kernel_size),
        .bias        (bias),
        .due         (due),
        .exp_val     (exp_val),
        .n_pushed    (n_pushed),
        .done        (done)
    );

    ////////////////////////////////////////
    // Output checks
    ////////////////////////////////////////

    // Sampled mid-cycle, away from the edges that move data
    a_no_extra: assert property (@(negedge clk) disable iff (!rstn) out_valid |-> due)
        else begin
            n_unexpected++;
            $display("Unexpected out_valid pulse at %0t", $time);
        end

    a_no_miss: assert property (@(negedge clk) disable iff (!rstn) due |-> out_valid)
        else begin
            n_missing++;
            $display("Missing out_valid pulse at %0t, expected pixel %0d", $time, exp_val);
        end

    a_value: assert property (@(negedge clk) disable iff (!rstn)
                              (out_valid && due) |-> (out_psum == exp_val))
        else begin
            n_mismatch++;
            $display("Mismatch at %0t: out_psum expected %0d, got %0d",
                     $time, exp_val, out_psum);
        end

    always @(negedge clk) begin
        if (rstn && out_valid) begin
            n_seen++;
        end
    end

    ////////////////////////////////////////
    // Watchdog and report
    ////////////////////////////////////////

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Timeout: run not finished after %0d cycles", WATCHDOG_CYC);
        $display("Test failed");
        $finish;
    end

    initial begin
        int n_count;
        while (!done) begin
            @(posedge clk);
        end
        @(negedge clk);
        #1;
        n_count = (n_seen != n_pushed) ? 1 : 0;
        if (n_count != 0) begin
            $display("Result count wrong: %0d windows sent, %0d results seen",
                     n_pushed, n_seen);
        end
        $display("Errors: mismatch %0d, unexpected %0d, missing %0d, count %0d",
                 n_mismatch, n_unexpected, n_missing, n_count);
        if (n_mismatch + n_unexpected + n_missing + n_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
conv_pkg.sv
pe_mult.sv
pe_ctrl.sv
pe.sv
row_skew.sv
conv_column.sv
tb_conv_model.sv
tb_conv_column.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the conv column testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_conv_column \
    -f files.f \
    -o sim_conv_column

./obj_dir/sim_conv_column | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass"
    exit 1
fi
